/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fpu_unit
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -j 0
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+verif
design/fpu_pkg.sv
design/fp_mul.sv
design/rsqrt_step.sv
design/fp_sqrt.sv
design/fpu_unit.sv
verif/tb_fpu_unit.sv

/* design/fp_mul.sv */
`timescale 1ns/1ns

module fp_mul (
   input  fpu_pkg::fp32_t     a,
   input  fpu_pkg::fp32_t     b,
   output fpu_pkg::fpu_resp_t resp
);
   import fpu_pkg::*;

   fp_exp_t            ea;
   fp_exp_t            eb;
   fp_exp_t            ea_eff;
   fp_exp_t            eb_eff;
   logic [23:0]        sig_a;
   logic [23:0]        sig_b;
   logic [47:0]        prod;
   logic [5:0]         lz;
   logic [47:0]        norm;
   logic signed [10:0] be;
   logic [5:0]         sh;
   logic [47:0]        lost_mask;
   logic [47:0]        shifted;
   logic               grd;
   logic               rbit;
   logic               stk;
   logic               up;
   logic [24:0]        rnd;
   logic [9:0]         exp_out;
   logic               sy;
   logic               a_nan;
   logic               b_nan;
   logic               a_inf;
   logic               b_inf;
   logic               a_zero;
   logic               b_zero;

   function automatic logic [5:0] lzc48(input logic [47:0] v);
      logic [5:0] n;
      n = 6'd48;
      for (int i = 0; i < 48; i++) begin
         if (v[i]) begin
            n = 6'(47 - i);
         end
      end
      return n;
   endfunction

   always_comb begin
      ea     = a[30:23];
      eb     = b[30:23];
      // subnormals carry exponent one and no hidden bit
      ea_eff = (ea == 8'd0) ? 8'd1 : ea;
      eb_eff = (eb == 8'd0) ? 8'd1 : eb;
      sig_a  = {ea != 8'd0, a[22:0]};
      sig_b  = {eb != 8'd0, b[22:0]};
      prod   = 48'(sig_a) * 48'(sig_b);
      lz     = lzc48(prod);
      norm   = prod << lz;
      be     = 11'(ea_eff) + 11'(eb_eff) - 11'd126 - 11'(lz);

      // denormalize when the biased exponent drops below one
      if (be > 11'sd0) begin
         sh = 6'd0;
      end else if (be < -11'sd47) begin
         sh = 6'd48;
      end else begin
         sh = 6'(11'sd1 - be);
      end
      lost_mask = (48'd1 << sh) - 48'd1;
      shifted   = norm >> sh;

      grd  = shifted[23];
      rbit = shifted[22];
      stk  = (|shifted[21:0]) | (|(norm & lost_mask));
      up   = grd && (rbit || stk || shifted[24]);
      rnd  = {1'b0, shifted[47:24]} + 25'(up);

      // rounding carry bumps the exponent, or lifts a subnormal to normal
      exp_out = (be > 11'sd0) ? 10'(be) + 10'(rnd[24]) : 10'(rnd[23]);

      sy     = a[31] ^ b[31];
      a_nan  = (ea == 8'hff) && (a[22:0] != 23'd0);
      b_nan  = (eb == 8'hff) && (b[22:0] != 23'd0);
      a_inf  = (ea == 8'hff) && (a[22:0] == 23'd0);
      b_inf  = (eb == 8'hff) && (b[22:0] == 23'd0);
      a_zero = (a[30:0] == 31'd0);
      b_zero = (b[30:0] == 31'd0);

      resp = '0;
      if (a_nan) begin
         resp.result = {a[31], 8'hff, 1'b1, a[21:0]};
      end else if (b_nan) begin
         resp.result = {b[31], 8'hff, 1'b1, b[21:0]};
      end else if ((a_inf && b_zero) || (a_zero && b_inf)) begin
         resp.result        = FP_QNAN_INVALID;
         resp.flags.invalid = 1'b1;
      end else if (a_inf || b_inf) begin
         resp.result = {sy, 8'hff, 23'd0};
      end else if (a_zero || b_zero) begin
         resp.result = {sy, 31'd0};
      end else if (exp_out >= 10'd255) begin
         resp.result         = {sy, 8'hff, 23'd0};
         resp.flags.overflow = 1'b1;
      end else begin
         resp.result = {sy, exp_out[7:0], rnd[22:0]};
      end
   end

endmodule

/* design/fp_sqrt.sv */
`timescale 1ns/1ns

module fp_sqrt (
   input  logic               clk,
   input  logic               rst,
   input  logic               in_valid,
   input  fpu_pkg::fp32_t     x,
   output logic               out_valid,
   output fpu_pkg::fpu_resp_t resp
);
   import fpu_pkg::*;

   typedef enum logic [2:0] {
      SQ_NORMAL,
      SQ_NAN,
      SQ_PINF,
      SQ_ZERO,
      SQ_NEG
   } sq_cls_e;

   typedef struct packed {
      logic [24:0] man;
      fp_exp_t     half_exp;
      sq_cls_e     cls;
      fp32_t       spec;
   } sq_stage_t;

   logic [1:FPU_LATENCY] vld;
   fp_exp_t              e_in;
   fp_man_t              f_in;
   logic [4:0]           lz;
   fp_man_t              fn;
   logic signed [9:0]    es;
   logic signed [9:0]    exp_tmp;
   logic [24:0]          man_c;
   sq_cls_e              cls_c;
   fp32_t                spec_c;
   sq_stage_t            s1;
   sq_stage_t            s2;
   sq_stage_t            s3;
   sq_cls_e              s4_cls;
   rsqrt_fix_t           s2_est;
   rsqrt_fix_t           s3_est;
   rsqrt_fix_t           chain_a [0:NEWTON_PER_STAGE];
   rsqrt_fix_t           chain_b [0:NEWTON_PER_STAGE];
   logic [52:0]          prod;
   logic [24:0]          q;
   logic [25:0]          lo;
   logic [25:0]          hi;
   logic [51:0]          lo_sq;
   logic [51:0]          hi_sq;
   logic [51:0]          target;
   logic [24:0]          root;
   fp_exp_t              root_exp;

   function automatic logic [4:0] lzc23(input fp_man_t v);
      logic [4:0] n;
      n = 5'd23;
      for (int i = 0; i < 23; i++) begin
         if (v[i]) begin
            n = 5'(22 - i);
         end
      end
      return n;
   endfunction

   // unpack: mantissa in [1,4) with an even exponent
   always_comb begin
      e_in    = x[30:23];
      f_in    = x[22:0];
      lz      = lzc23(f_in);
      fn      = (e_in != 8'd0) ? f_in : fp_man_t'(f_in << (lz + 5'd1));
      es      = (e_in != 8'd0) ? 10'(e_in) : -10'(lz);
      man_c   = es[0] ? {2'b01, fn} : {1'b1, fn, 1'b0};
      exp_tmp = (es >>> 1) + (es[0] ? 10'sd64 : 10'sd63);

      if (e_in == 8'hff && f_in != 23'd0) begin
         cls_c  = SQ_NAN;
         spec_c = {x[31], 8'hff, 1'b1, x[21:0]};
      end else if (x[30:0] == 31'd0) begin
         cls_c  = SQ_ZERO;
         spec_c = x;
      end else if (x[31]) begin
         cls_c  = SQ_NEG;
         spec_c = FP_QNAN_INVALID;
      end else if (e_in == 8'hff) begin
         cls_c  = SQ_PINF;
         spec_c = x;
      end else begin
         cls_c  = SQ_NORMAL;
         spec_c = x;
      end
   end

   assign chain_a[0] = RSQRT_ONE;
   assign chain_b[0] = s2_est;

   for (genvar i = 0; i < NEWTON_PER_STAGE; i++) begin : g_newton
      rsqrt_step u_step_a (
         .man   (s1.man),
         .x_in  (chain_a[i]),
         .x_out (chain_a[i+1])
      );
      rsqrt_step u_step_b (
         .man   (s2.man),
         .x_in  (chain_b[i]),
         .x_out (chain_b[i+1])
      );
   end

   // root = man * est / 2, candidate at 23 fraction bits
   always_comb begin
      prod   = 53'(s3.man) * 53'(s3_est);
      q      = {1'b0, prod[50:27]} + 25'(prod[26]);
      lo     = {q, 1'b0} - 26'd1;
      hi     = {q, 1'b0} + 26'd1;
      lo_sq  = 52'(lo) * 52'(lo);
      hi_sq  = 52'(hi) * 52'(hi);
      target = {2'b00, s3.man, 25'd0};
      // compare against the half-ulp boundaries on both sides
      if (target < lo_sq) begin
         root = q - 25'd1;
      end else if (target >= hi_sq) begin
         root = q + 25'd1;
      end else begin
         root = q;
      end
      root_exp = s3.half_exp + fp_exp_t'(root[24]);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         vld <= '0;
      end else begin
         vld <= {in_valid, vld[1:FPU_LATENCY-1]};
      end
   end

   always_ff @(posedge clk) begin
      s1     <= '{man: man_c, half_exp: exp_tmp[7:0], cls: cls_c, spec: spec_c};
      s2     <= s1;
      s2_est <= chain_a[NEWTON_PER_STAGE];
      s3     <= s2;
      s3_est <= chain_b[NEWTON_PER_STAGE];
      s4_cls <= s3.cls;
      if (s3.cls == SQ_NORMAL) begin
         resp.result <= {1'b0, root_exp, root[22:0]};
      end else begin
         resp.result <= s3.spec;
      end
      resp.flags.invalid  <= (s3.cls == SQ_NEG);
      resp.flags.overflow <= 1'b0;
   end

   assign out_valid = vld[FPU_LATENCY];

   // an ordinary root is positive and finite
   a_root_range: assert property (@(posedge clk) disable iff (rst)
      out_valid && s4_cls == SQ_NORMAL |-> !resp.result[31] && resp.result[30:23] != 8'hff);

   a_latency: assert property (@(posedge clk) disable iff (rst)
      !$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3) && !$past(rst, 4)
      |-> out_valid == $past(in_valid, FPU_LATENCY));

endmodule

/* design/fpu_pkg.sv */
package fpu_pkg;

   // raw single precision and its fields
   typedef logic [31:0] fp32_t;
   typedef logic [7:0]  fp_exp_t;
   typedef logic [22:0] fp_man_t;

   // 2 integer bits, 26 fraction bits
   typedef logic [27:0] rsqrt_fix_t;

   typedef enum logic {
      FPU_MUL  = 1'b0,
      FPU_SQRT = 1'b1
   } fpu_op_e;

   typedef struct packed {
      logic invalid;
      logic overflow;
   } fp_flags_t;

   typedef struct packed {
      fpu_op_e op;
      fp32_t   a;
      fp32_t   b;
   } fpu_req_t;

   typedef struct packed {
      fp32_t     result;
      fp_flags_t flags;
   } fpu_resp_t;

   // in_valid to out_valid, both pipelines
   localparam int FPU_LATENCY = 4;

   // newton chain, split over two stages
   localparam int NEWTON_ITERS     = 6;
   localparam int NEWTON_PER_STAGE = NEWTON_ITERS / 2;

   // initial estimate of the chain
   localparam rsqrt_fix_t RSQRT_ONE = 28'h400_0000;

   localparam fp32_t FP_QNAN_INVALID = 32'hffc0_0000;

endpackage

/* design/fpu_unit.sv */
`timescale 1ns/1ns

module fpu_unit (
   input  logic               clk,
   input  logic               rst,
   input  logic               in_valid,
   input  fpu_pkg::fpu_req_t  in_req,
   output logic               out_valid,
   output fpu_pkg::fpu_resp_t out_resp
);
   import fpu_pkg::*;

   typedef struct packed {
      fpu_op_e   op;
      fpu_resp_t resp;
   } mul_stage_t;

   logic [1:FPU_LATENCY] vld;
   fpu_req_t             s1_req;
   fpu_resp_t            mul_resp;
   mul_stage_t           stg [2:FPU_LATENCY];
   logic                 sqrt_valid;
   fpu_resp_t            sqrt_resp;

   fp_mul u_fp_mul (
      .a    (s1_req.a),
      .b    (s1_req.b),
      .resp (mul_resp)
   );

   // samples the same edge as s1_req
   fp_sqrt u_fp_sqrt (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .x         (in_req.a),
      .out_valid (sqrt_valid),
      .resp      (sqrt_resp)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         vld <= '0;
      end else begin
         vld <= {in_valid, vld[1:FPU_LATENCY-1]};
      end
   end

   // product delay line, matched to the sqrt depth
   always_ff @(posedge clk) begin
      s1_req <= in_req;
      stg[2] <= '{op: s1_req.op, resp: mul_resp};
      for (int k = 3; k <= FPU_LATENCY; k++) begin
         stg[k] <= stg[k-1];
      end
   end

   assign out_valid = vld[FPU_LATENCY];
   assign out_resp  = (stg[FPU_LATENCY].op == FPU_SQRT) ? sqrt_resp : stg[FPU_LATENCY].resp;

   // both pipelines advance in lockstep
   a_lockstep: assert property (@(posedge clk) disable iff (rst)
      vld[FPU_LATENCY] == sqrt_valid);

   a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid);

endmodule

/* design/rsqrt_step.sv */
`timescale 1ns/1ns

module rsqrt_step (
   input  logic [24:0]         man,
   input  fpu_pkg::rsqrt_fix_t x_in,
   output fpu_pkg::rsqrt_fix_t x_out
);
   import fpu_pkg::*;

   // man is taken as a quarter of the mantissa, 25 fraction bits
   logic [80:0]  mx2;
   logic [80:0]  t;
   logic [108:0] p;
   logic         up;

   // x * (3 - m * x^2), 77 fraction bits before the last product
   assign mx2 = 81'(man) * 81'(x_in) * 81'(x_in);
   assign t   = (81'd3 << 77) - mx2;
   assign p   = 109'(t) * 109'(x_in);

   // halve and drop to 26 fraction bits, nearest even
   assign up    = p[77] && ((|p[76:0]) || p[78]);
   assign x_out = p[105:78] + rsqrt_fix_t'(up);

endmodule

/* verif/fpu_model.svh */
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

// bit pattern to real, subnormals included
function automatic real fp32_to_real(input fp32_t v);
   real mag;
   if (v[30:23] == 8'd0) begin
      // fraction times 2^-149
      mag = real'(v[22:0]) * $bitstoreal({1'b0, 11'(1023 - 149), 52'd0});
   end else begin
      mag = $bitstoreal({1'b0, 11'(int'(v[30:23]) - 127 + 1023), v[22:0], 29'd0});
   end
   return v[31] ? -mag : mag;
endfunction

// double down to single, nearest even, gradual underflow
function automatic fp32_t round_to_single(input real r, output logic ovf);
   logic [63:0] d;
   logic [63:0] sig;
   logic [63:0] kept;
   logic [63:0] rem;
   logic [63:0] half;
   int          eb;
   int          sh;
   d   = $realtobits(r);
   ovf = 1'b0;
   if (d[62:0] == 63'd0) begin
      return {d[63], 31'd0};
   end
   sig = {11'd0, 1'b1, d[51:0]};
   eb  = int'(d[62:52]) - 1023 + 127;
   // 53 bits to 24, plus the extra shift below the normal range
   sh  = (eb >= 1) ? 29 : 30 - eb;
   if (sh > 60) begin
      sh = 60;
   end
   kept = sig >> sh;
   rem  = sig & ((64'd1 << sh) - 64'd1);
   half = 64'd1 << (sh - 1);
   if (rem > half || (rem == half && kept[0])) begin
      kept = kept + 64'd1;
   end
   // a carry into bit 23 turns into the smallest normal by itself
   if (eb < 1) begin
      return {d[63], 31'(kept)};
   end
   if (kept[24]) begin
      kept = kept >> 1;
      eb++;
   end
   if (eb >= 255) begin
      ovf = 1'b1;
      return {d[63], 8'hff, 23'd0};
   end
   return {d[63], 8'(eb), kept[22:0]};
endfunction

function automatic logic is_nan(input fp32_t v);
   return (v[30:23] == 8'hff) && (v[22:0] != 23'd0);
endfunction

function automatic logic is_inf(input fp32_t v);
   return (v[30:23] == 8'hff) && (v[22:0] == 23'd0);
endfunction

function automatic logic is_zero(input fp32_t v);
   return v[30:0] == 31'd0;
endfunction

function automatic fpu_resp_t mul_model(input fp32_t a, input fp32_t b);
   fpu_resp_t r;
   logic      ovf;
   logic      sgn;
   r   = '0;
   sgn = a[31] ^ b[31];
   if (is_nan(a)) begin
      r.result = a | 32'h0040_0000;
   end else if (is_nan(b)) begin
      r.result = b | 32'h0040_0000;
   end else if ((is_inf(a) && is_zero(b)) || (is_zero(a) && is_inf(b))) begin
      r.result        = FP_QNAN_INVALID;
      r.flags.invalid = 1'b1;
   end else if (is_inf(a) || is_inf(b)) begin
      r.result = {sgn, 8'hff, 23'd0};
   end else if (is_zero(a) || is_zero(b)) begin
      r.result = {sgn, 31'd0};
   end else begin
      // double product of two singles is exact
      r.result         = round_to_single(fp32_to_real(a) * fp32_to_real(b), ovf);
      r.flags.overflow = ovf;
   end
   return r;
endfunction

function automatic fpu_resp_t sqrt_model(input fp32_t x);
   fpu_resp_t r;
   logic      ovf;
   r = '0;
   if (is_nan(x)) begin
      r.result = x | 32'h0040_0000;
   end else if (is_zero(x) || (is_inf(x) && !x[31])) begin
      r.result = x;
   end else if (x[31]) begin
      r.result        = FP_QNAN_INVALID;
      r.flags.invalid = 1'b1;
   end else begin
      // rounding twice is safe for sqrt at 53 and 24 bits
      r.result = round_to_single($sqrt(fp32_to_real(x)), ovf);
   end
   return r;
endfunction

`endif

/* verif/tb_fpu_unit.sv */
`timescale 1ns/1ns

module tb_fpu_unit;
   import fpu_pkg::*;

   `include "fpu_model.svh"

   localparam int N_MUL       = 300;
   localparam int N_SQRT      = 300;
   localparam int N_SPEC      = 150;
   localparam int N_EDGE      = 200;
   localparam int N_STREAM    = 400;
   localparam int NUM_REQ     = N_MUL + N_SQRT + N_SPEC + N_EDGE + N_STREAM;
   localparam int WATCHDOG_NS = NUM_REQ * 40 * 2 + 2000;

   // operand classes
   localparam int C_NORMAL = 0;
   localparam int C_SUB    = 1;
   localparam int C_BIG    = 2;
   localparam int C_TINY   = 3;
   localparam int C_SPEC   = 4;

   typedef struct packed {
      fpu_req_t  req;
      fpu_resp_t resp;
      int        issue;
   } expect_t;

   logic      clk;
   logic      rst;
   logic      in_valid;
   fpu_req_t  in_req;
   logic      out_valid;
   fpu_resp_t out_resp;
   int        seed = 32'h96dd;
   int        cyc = 0;
   int        errors = 0;
   int        checks = 0;
   expect_t   exp_q[$];
   expect_t   head;
   fp32_t     a;
   fp32_t     b;
   logic [31:0] u;

   fpu_unit u_fpu_unit (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_resp  (out_resp)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [31:0] rand_u32();
      return $random(seed);
   endfunction

   function automatic fp32_t rand_operand(input int cls);
      logic [31:0] r;
      logic [31:0] f;
      fp_exp_t     e;
      r = rand_u32();
      f = rand_u32();
      case (cls)
         C_SUB:   e = 8'd0;
         C_BIG:   e = 8'(150 + r % 105);
         C_TINY:  e = 8'(1 + r % 70);
         C_SPEC: begin
            e = (r[9:8] == 2'd0) ? 8'd0 : 8'hff;
            if (r[9:8] == 2'd1 || r[9:8] == 2'd0) begin
               f = 32'd0;
            end else begin
               // keep the payload non-zero
               f = f | 32'd1;
            end
         end
         default: e = 8'(1 + r % 254);
      endcase
      return {r[31], e, f[22:0]};
   endfunction

   // weighted so that edge classes come up often
   function automatic int rand_class();
      logic [31:0] r;
      r = rand_u32() % 16;
      if (r < 6) return C_NORMAL;
      if (r < 9) return C_SUB;
      if (r < 11) return C_BIG;
      if (r < 13) return C_TINY;
      return C_SPEC;
   endfunction

   function automatic string op_text(input fpu_op_e op);
      return (op == FPU_SQRT) ? "sqrt" : "mul";
   endfunction

   task automatic send(input fpu_op_e op, input fp32_t x, input fp32_t y);
      expect_t ent;
      ent.req   = '{op: op, a: x, b: y};
      ent.resp  = (op == FPU_MUL) ? mul_model(x, y) : sqrt_model(x);
      ent.issue = cyc;
      in_valid  = 1'b1;
      in_req    = ent.req;
      exp_q.push_back(ent);
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   // compare each result with the oldest pending request
   always @(negedge clk) begin
      if (out_valid) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("out_valid went high at %0t with no request in flight", $time);
         end else begin
            head = exp_q.pop_front();
            checks++;
            if (cyc != head.issue + FPU_LATENCY) begin
               errors++;
               $display("Error %0t: result in cycle %0d, request in cycle %0d",
                        $time, cyc, head.issue);
            end
            if (out_resp !== head.resp) begin
               errors++;
               $display("Error %0t: %s a=%h b=%h expected %h/%b got %h/%b", $time,
                        op_text(head.req.op), head.req.a, head.req.b, head.resp.result,
                        head.resp.flags, out_resp.result, out_resp.flags);
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout at %0t, results stopped arriving, %0d still pending",
               $time, exp_q.size());
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      rst      = 1'b1;
      in_valid = 1'b0;
      in_req   = '0;
      @(negedge clk);
      // a strobe during reset must be dropped
      in_valid = 1'b1;
      in_req   = '{op: FPU_MUL, a: 32'h3f80_0000, b: 32'h4000_0000};
      @(negedge clk);
      rst      = 1'b0;
      in_valid = 1'b0;
      repeat (FPU_LATENCY + 1) begin
         checks++;
         if (out_valid) begin
            errors++;
            $display("Error %0t: out_valid high right after reset", $time);
         end
         @(negedge clk);
      end

      repeat (N_MUL) send(FPU_MUL, rand_operand(C_NORMAL), rand_operand(C_NORMAL));

      repeat (N_SQRT) begin
         u    = rand_u32();
         a    = rand_operand(u[0] ? C_SUB : C_NORMAL);
         a[31] = 1'b0;
         send(FPU_SQRT, a, rand_operand(C_NORMAL));
      end

      // specials on either side and for both ops
      repeat (N_SPEC) begin
         u = rand_u32();
         a = rand_operand(C_SPEC);
         b = rand_operand(rand_class());
         if (u[1] && u[2]) begin
            a = rand_operand(C_NORMAL) | 32'h8000_0000;
         end
         if (u[0] && !u[1]) begin
            send(FPU_MUL, b, a);
         end else begin
            send(u[1] ? FPU_SQRT : FPU_MUL, a, b);
         end
      end

      // overflow and underflow products
      repeat (N_EDGE) begin
         u = rand_u32();
         if (u[0]) begin
            send(FPU_MUL, rand_operand(C_BIG), rand_operand(C_BIG));
         end else begin
            send(FPU_MUL, rand_operand(C_TINY), rand_operand(u[1] ? C_SUB : C_TINY));
         end
      end

      // mixed stream with occasional gaps
      repeat (N_STREAM) begin
         u = rand_u32();
         if (u[3:2] == 2'd0) begin
            repeat (1 + u[5:4]) @(negedge clk);
         end
         a = rand_operand(rand_class());
         b = rand_operand(rand_class());
         send(u[0] ? FPU_SQRT : FPU_MUL, a, b);
      end

      while (exp_q.size() != 0) @(negedge clk);
      repeat (FPU_LATENCY + 2) @(negedge clk);
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d results never arrived", exp_q.size());
      end
      $display("errors: %0d  checks: %0d", errors, checks);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
